// ==== rx_pkg.sv ====
package rx_pkg;

    //////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////

    // Integer data path
    localparam int xlen = 32;

    // Register file index
    localparam int reg_addr_w = 5;

    // CSR address space
    localparam int csr_addr_w = 12;

    // CSR address rides in the low bits of operand 2
    localparam int csr_addr_lsb = 0;

    //////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////

    // Operands, results, PCs and CSR data
    typedef logic [xlen-1:0] word_t;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef logic [csr_addr_w-1:0] csr_addr_t;

    //////////////////////////////////////////////////////////////
    // Operation encodings
    //////////////////////////////////////////////////////////////

    // Integer ALU operations
    // Compares at the bottom give 1 or 0
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_eq   = 4'd10,
        alu_ne   = 4'd11,
        alu_lt   = 4'd12,
        alu_ge   = 4'd13,
        alu_ltu  = 4'd14,
        alu_geu  = 4'd15
    } alu_op_t;

    // CSR access kinds
    typedef enum logic [1:0] {
        csr_read  = 2'd0,
        csr_write = 2'd1,
        csr_set   = 2'd2,
        csr_clear = 2'd3
    } csr_op_t;

endpackage

// ==== ex_bus_if.sv ====
interface ex_bus_if;

    // Instruction valid in EX
    logic valid;

    // ALU controls and operands
    rx_pkg::alu_op_t alu_op;
    rx_pkg::word_t   op_a;
    rx_pkg::word_t   op_b;

    // Branch info
    logic          is_branch;
    rx_pkg::word_t branch_target;

    // CSR instruction marker
    logic csr_access;

    // PC of the instruction in EX
    rx_pkg::word_t pc;

    // Pipeline register side, owns every field
    modport decode (
        output valid,
        output alu_op,
        output op_a,
        output op_b,
        output is_branch,
        output branch_target,
        output csr_access,
        output pc
    );

    // Integer ALU only sees the operation and operands
    modport alu (
        input alu_op,
        input op_a,
        input op_b
    );

    // Result select, branch decision and trap
    modport result (
        input valid,
        input is_branch,
        input branch_target,
        input csr_access
    );

endinterface

// ==== ex_decode_reg.sv ====
module ex_decode_reg (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    // Decoded fields from ID
    input  logic              valid_i,
    input  rx_pkg::alu_op_t   alu_op_i,
    input  rx_pkg::word_t     op_a_i,
    input  rx_pkg::word_t     op_b_i,
    input  rx_pkg::reg_addr_t rd_addr_i,
    input  logic              mem_req_i,
    input  logic              mem_wen_i,
    input  logic              reg_wen_i,
    input  rx_pkg::word_t     pc_i,
    input  rx_pkg::word_t     branch_target_i,
    input  logic              is_branch_i,
    input  logic              csr_access_i,
    input  rx_pkg::csr_op_t   csr_op_i,
    // Registered controls towards MEM and CSRs
    output rx_pkg::reg_addr_t rd_addr_o,
    output logic              mem_req_o,
    output logic              mem_wen_o,
    output logic              reg_wen_o,
    output rx_pkg::csr_addr_t csr_addr_o,
    output rx_pkg::word_t     csr_wdata_o,
    output rx_pkg::csr_op_t   csr_op_o,
    // Registered fields for ALU and result logic
    ex_bus_if.decode          bus
);

    //////////////////////////////////////////////////////////////
    // ID to EX register
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.valid         <= 1'b0;
            bus.alu_op        <= rx_pkg::alu_add;
            bus.op_a          <= '0;
            bus.op_b          <= '0;
            bus.is_branch     <= 1'b0;
            bus.branch_target <= '0;
            bus.csr_access    <= 1'b0;
            bus.pc            <= '0;
            rd_addr_o         <= '0;
            mem_req_o         <= 1'b0;
            mem_wen_o         <= 1'b0;
            reg_wen_o         <= 1'b0;
            csr_addr_o        <= '0;
            csr_wdata_o       <= '0;
            csr_op_o          <= rx_pkg::csr_read;
        end else if (!stall_i) begin
            if (flush_i) begin
                // Bubble, kill side effects only
                bus.valid      <= 1'b0;
                bus.is_branch  <= 1'b0;
                bus.csr_access <= 1'b0;
                mem_req_o      <= 1'b0;
                mem_wen_o      <= 1'b0;
                reg_wen_o      <= 1'b0;
                csr_op_o       <= rx_pkg::csr_read;
            end else begin
                bus.valid         <= valid_i;
                bus.alu_op        <= alu_op_i;
                bus.op_a          <= op_a_i;
                bus.op_b          <= op_b_i;
                bus.is_branch     <= is_branch_i;
                bus.branch_target <= branch_target_i;
                bus.csr_access    <= csr_access_i;
                bus.pc            <= pc_i;
                rd_addr_o         <= rd_addr_i;
                mem_req_o         <= mem_req_i;
                mem_wen_o         <= mem_wen_i;
                reg_wen_o         <= reg_wen_i;
                csr_op_o          <= csr_op_i;
                // CSR fields only move on a CSR instruction
                if (csr_access_i) begin
                    // Write data comes in on operand 1
                    csr_wdata_o <= op_a_i;
                    csr_addr_o  <= op_b_i[rx_pkg::csr_addr_lsb +: rx_pkg::csr_addr_w];
                end
            end
        end
    end

    // Bubble must never leave a live or CSR instruction behind
    a_flush_bubble: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (flush_i && !stall_i) |=> (!bus.valid && !bus.csr_access)
    );

endmodule

// ==== ex_alu.sv ====
module ex_alu (
    ex_bus_if.alu         bus,
    output rx_pkg::word_t res_o
);

    //////////////////////////////////////////////////////////////
    // Integer ALU
    //////////////////////////////////////////////////////////////

    // Shift amount, low bits of op_b
    logic [$clog2(rx_pkg::xlen)-1:0] shamt;

    // Signed views for compares and arithmetic shift
    logic signed [rx_pkg::xlen-1:0] op_a_s;
    logic signed [rx_pkg::xlen-1:0] op_b_s;

    assign shamt  = bus.op_b[$clog2(rx_pkg::xlen)-1:0];
    assign op_a_s = bus.op_a;
    assign op_b_s = bus.op_b;

    always_comb begin
        unique case (bus.alu_op)
            rx_pkg::alu_add:  res_o = bus.op_a + bus.op_b;
            rx_pkg::alu_sub:  res_o = bus.op_a - bus.op_b;
            rx_pkg::alu_and:  res_o = bus.op_a & bus.op_b;
            rx_pkg::alu_or:   res_o = bus.op_a | bus.op_b;
            rx_pkg::alu_xor:  res_o = bus.op_a ^ bus.op_b;
            rx_pkg::alu_sll:  res_o = bus.op_a << shamt;
            rx_pkg::alu_srl:  res_o = bus.op_a >> shamt;
            // Sign bit fills from the left
            rx_pkg::alu_sra:  res_o = rx_pkg::word_t'(op_a_s >>> shamt);
            // Compares, zero extended single bit
            rx_pkg::alu_slt:  res_o = rx_pkg::word_t'(op_a_s < op_b_s);
            rx_pkg::alu_sltu: res_o = rx_pkg::word_t'(bus.op_a < bus.op_b);
            rx_pkg::alu_eq:   res_o = rx_pkg::word_t'(bus.op_a == bus.op_b);
            rx_pkg::alu_ne:   res_o = rx_pkg::word_t'(bus.op_a != bus.op_b);
            rx_pkg::alu_lt:   res_o = rx_pkg::word_t'(op_a_s < op_b_s);
            rx_pkg::alu_ge:   res_o = rx_pkg::word_t'(op_a_s >= op_b_s);
            rx_pkg::alu_ltu:  res_o = rx_pkg::word_t'(bus.op_a < bus.op_b);
            rx_pkg::alu_geu:  res_o = rx_pkg::word_t'(bus.op_a >= bus.op_b);
            default:          res_o = '0;
        endcase
    end

    // Branch logic only looks at bit 0, upper bits must stay clear
    always_comb begin
        if (bus.alu_op == rx_pkg::alu_eq) begin
            a_eq_is_flag: assert (res_o <= rx_pkg::word_t'(1))
                else $error("ex_alu: alu_eq result above 1");
        end
    end

endmodule

// ==== ex_result.sv ====
module ex_result #(
    parameter bit isa_c = 1'b0
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          stall_i,
    // Unregistered ID field, marks the first CSR cycle
    input  logic          csr_access_i,
    input  rx_pkg::word_t csr_rdata_i,
    input  rx_pkg::word_t alu_res_i,
    ex_bus_if.result      bus,
    output rx_pkg::word_t result_o,
    output logic          branch_taken_o,
    output logic          trap_o
);

    // High in the cycle right after a CSR instruction enters EX
    logic          csr_cyc1;
    // CSR read data seen in that first cycle
    rx_pkg::word_t csr_rdata_q;
    // Taken branch to a target off the 4-byte grid
    logic          misaligned;

    //////////////////////////////////////////////////////////////
    // CSR read data capture
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csr_cyc1 <= 1'b0;
        end else if (stall_i) begin
            csr_cyc1 <= 1'b0;
        end else begin
            csr_cyc1 <= csr_access_i;
        end
    end

    // CSR file may move on while EX is frozen
    always_ff @(posedge clk_i) begin
        if (csr_cyc1) begin
            csr_rdata_q <= csr_rdata_i;
        end
    end

    //////////////////////////////////////////////////////////////
    // Result, branch and trap
    //////////////////////////////////////////////////////////////

    always_comb begin
        if (!bus.csr_access) begin
            result_o = alu_res_i;
        end else if (csr_cyc1) begin
            result_o = csr_rdata_i;
        end else begin
            result_o = csr_rdata_q;
        end
    end

    // Compare flag sits in bit 0
    assign branch_taken_o = bus.is_branch && result_o[0];

    // Compressed ISA allows halfword targets
    assign misaligned = isa_c ? 1'b0 : (branch_taken_o && bus.branch_target[1]);
    assign trap_o     = bus.valid && misaligned;

    a_trap_taken: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        trap_o |-> branch_taken_o
    );

    // Frozen CSR instruction keeps showing its first-cycle data
    a_csr_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && bus.csr_access) |=> $stable(result_o)
    );

endmodule

// ==== ex_stage.sv ====
module ex_stage #(
    parameter bit isa_c = 1'b0
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    // Pipeline control
    input  logic              stall_i,
    input  logic              flush_i,
    // Decoded fields from ID
    input  logic              valid_i,
    input  rx_pkg::alu_op_t   alu_op_i,
    input  rx_pkg::word_t     op_a_i,
    input  rx_pkg::word_t     op_b_i,
    input  rx_pkg::reg_addr_t rd_addr_i,
    input  logic              mem_req_i,
    input  logic              mem_wen_i,
    input  logic              reg_wen_i,
    input  rx_pkg::word_t     pc_i,
    input  rx_pkg::word_t     branch_target_i,
    input  logic              is_branch_i,
    input  logic              csr_access_i,
    input  rx_pkg::csr_op_t   csr_op_i,
    // From CSR file
    input  rx_pkg::word_t     csr_rdata_i,
    // To MEM
    output logic              valid_o,
    output rx_pkg::reg_addr_t rd_addr_o,
    output logic              mem_req_o,
    output logic              mem_wen_o,
    output logic              reg_wen_o,
    output rx_pkg::word_t     alu_result_o,
    // To IF
    output logic              branch_taken_o,
    output rx_pkg::word_t     branch_target_o,
    output logic              trap_o,
    // To CSR file
    output rx_pkg::word_t     pc_o,
    output logic              csr_access_o,
    output rx_pkg::csr_addr_t csr_addr_o,
    output rx_pkg::word_t     csr_wdata_o,
    output rx_pkg::csr_op_t   csr_op_o
);

    //////////////////////////////////////////////////////////////
    // Stage internals
    //////////////////////////////////////////////////////////////

    ex_bus_if ex_bus ();

    // Raw ALU output before CSR select
    rx_pkg::word_t alu_res;

    ex_decode_reg u_decode_reg (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .valid_i         (valid_i),
        .alu_op_i        (alu_op_i),
        .op_a_i          (op_a_i),
        .op_b_i          (op_b_i),
        .rd_addr_i       (rd_addr_i),
        .mem_req_i       (mem_req_i),
        .mem_wen_i       (mem_wen_i),
        .reg_wen_i       (reg_wen_i),
        .pc_i            (pc_i),
        .branch_target_i (branch_target_i),
        .is_branch_i     (is_branch_i),
        .csr_access_i    (csr_access_i),
        .csr_op_i        (csr_op_i),
        .rd_addr_o       (rd_addr_o),
        .mem_req_o       (mem_req_o),
        .mem_wen_o       (mem_wen_o),
        .reg_wen_o       (reg_wen_o),
        .csr_addr_o      (csr_addr_o),
        .csr_wdata_o     (csr_wdata_o),
        .csr_op_o        (csr_op_o),
        .bus             (ex_bus.decode)
    );

    ex_alu u_alu (
        .bus   (ex_bus.alu),
        .res_o (alu_res)
    );

    ex_result #(
        .isa_c (isa_c)
    ) u_result (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .csr_access_i   (csr_access_i),
        .csr_rdata_i    (csr_rdata_i),
        .alu_res_i      (alu_res),
        .bus            (ex_bus.result),
        .result_o       (alu_result_o),
        .branch_taken_o (branch_taken_o),
        .trap_o         (trap_o)
    );

    // Registered fields straight out of the bus
    assign valid_o         = ex_bus.valid;
    assign branch_target_o = ex_bus.branch_target;
    assign pc_o            = ex_bus.pc;
    assign csr_access_o    = ex_bus.csr_access;

endmodule

// ==== ex_checker.sv ====
module ex_checker (
    input  logic              clk_i,
    input  logic              check_en_i,
    input  int                line_i,
    // Watched DUT outputs
    input  logic              valid_i,
    input  rx_pkg::word_t     alu_result_i,
    input  logic              branch_taken_i,
    input  logic              trap_i,
    input  rx_pkg::csr_addr_t csr_addr_i,
    input  logic              mem_req_i,
    input  logic              reg_wen_i,
    input  logic              mem_wen_i,
    input  rx_pkg::reg_addr_t rd_addr_i,
    input  rx_pkg::word_t     pc_i,
    input  rx_pkg::word_t     branch_target_i,
    input  logic              csr_access_i,
    input  rx_pkg::word_t     csr_wdata_i,
    input  rx_pkg::csr_op_t   csr_op_i,
    output int                err_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cols      = 15;
    localparam int max_lines = 64;

    // Stimulus columns used by the register model
    localparam int col_stall  = 0;
    localparam int col_flush  = 1;
    localparam int col_op_a   = 4;
    localparam int col_target = 7;
    localparam int col_csr    = 8;

    // Expected columns of a line
    localparam int col_valid = 10;
    localparam int col_res   = 11;
    localparam int col_taken = 12;
    localparam int col_trap  = 13;
    localparam int col_addr  = 14;

    rx_pkg::word_t pat [0:max_lines*cols-1];
    int            err_cnt = 0;
    int            base;
    int            fd;

    // Registered fields that have no expected column
    rx_pkg::reg_addr_t exp_rd_addr;
    rx_pkg::word_t     exp_pc;
    rx_pkg::word_t     exp_target;
    logic              exp_csr_acc;
    rx_pkg::word_t     exp_wdata;
    rx_pkg::csr_op_t   exp_csr_op;

    assign err_cnt_o = err_cnt;

    // Expected columns come from the stimulus file
    initial begin
        exp_rd_addr = '0;
        exp_pc      = '0;
        exp_target  = '0;
        exp_csr_acc = 1'b0;
        exp_wdata   = '0;
        exp_csr_op  = rx_pkg::csr_read;
        for (int i = 0; i < max_lines * cols; i++) begin
            pat[i] = '1;
        end
        fd = $fopen("ex_patterns.txt", "r");
        if (fd != 0) begin
            $fclose(fd);
            $readmemh("ex_patterns.txt", pat);
        end
    end

    // Register contents after the edge that took line k
    task automatic track_line(input int k);
        int b;
        b = k * cols;
        if (pat[b+col_stall][0] == 1'b0) begin
            if (pat[b+col_flush][0]) begin
                // Bubble clears the CSR marker and op only
                exp_csr_acc = 1'b0;
                exp_csr_op  = rx_pkg::csr_read;
            end else begin
                // Rd index, PC and CSR op follow the line number
                exp_rd_addr = rx_pkg::reg_addr_t'(k);
                exp_pc      = rx_pkg::word_t'(k * 4);
                exp_target  = pat[b+col_target];
                exp_csr_acc = pat[b+col_csr][0];
                exp_csr_op  = rx_pkg::csr_op_t'(k % 4);
                if (pat[b+col_csr][0]) begin
                    exp_wdata = pat[b+col_op_a];
                end
            end
        end
    endtask

    task automatic compare(input string name, input rx_pkg::word_t exp,
                           input rx_pkg::word_t act, input int line);
        if (exp !== act) begin
            err_cnt++;
            $display("error at %0t: %s expected %h, actual %h (pattern line %0d)",
                     $time, name, exp, act, line);
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Compare on the falling edge after the loading edge
    //////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (check_en_i && line_i < max_lines) begin
            base = line_i * cols;
            track_line(line_i);
            compare("valid_o", pat[base+col_valid], {31'b0, valid_i}, line_i);
            compare("alu_result_o", pat[base+col_res], alu_result_i, line_i);
            compare("branch_taken_o", pat[base+col_taken], {31'b0, branch_taken_i}, line_i);
            compare("trap_o", pat[base+col_trap], {31'b0, trap_i}, line_i);
            compare("csr_addr_o", pat[base+col_addr], {20'b0, csr_addr_i}, line_i);
            // Request and write enables are driven from valid
            compare("mem_req_o", pat[base+col_valid], {31'b0, mem_req_i}, line_i);
            compare("mem_wen_o", pat[base+col_valid], {31'b0, mem_wen_i}, line_i);
            compare("reg_wen_o", pat[base+col_valid], {31'b0, reg_wen_i}, line_i);
            compare("rd_addr_o", rx_pkg::word_t'(exp_rd_addr),
                    rx_pkg::word_t'(rd_addr_i), line_i);
            compare("pc_o", exp_pc, pc_i, line_i);
            compare("branch_target_o", exp_target, branch_target_i, line_i);
            compare("csr_access_o", {31'b0, exp_csr_acc}, {31'b0, csr_access_i}, line_i);
            compare("csr_wdata_o", exp_wdata, csr_wdata_i, line_i);
            compare("csr_op_o", rx_pkg::word_t'(exp_csr_op),
                    rx_pkg::word_t'(csr_op_i), line_i);
        end
    end

endmodule

// ==== tb_ex_stage.sv ====
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          cols         = 15;
    localparam int          max_lines    = 64;
    localparam int          clk_period   = 40;
    localparam int          reset_cycles = 16;
    // Total idle cycles stay below the watchdog margin
    localparam int          gap_budget   = 40;
    localparam int unsigned rand_seed    = 32'h2d7dc7f2;

    //////////////////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////////////////

    logic              clk;
    logic              rst_n;
    logic              stall;
    logic              flush;
    logic              valid;
    rx_pkg::alu_op_t   alu_op;
    rx_pkg::word_t     op_a;
    rx_pkg::word_t     op_b;
    rx_pkg::reg_addr_t rd_addr;
    logic              mem_req;
    logic              mem_wen;
    logic              reg_wen;
    rx_pkg::word_t     pc;
    rx_pkg::word_t     branch_target;
    logic              is_branch;
    logic              csr_access;
    rx_pkg::csr_op_t   csr_op;
    rx_pkg::word_t     csr_rdata;

    logic              ex_valid;
    rx_pkg::reg_addr_t ex_rd_addr;
    logic              ex_mem_req;
    logic              ex_mem_wen;
    logic              ex_reg_wen;
    rx_pkg::word_t     ex_alu_result;
    logic              ex_branch_taken;
    rx_pkg::word_t     ex_branch_target;
    logic              ex_trap;
    rx_pkg::word_t     ex_pc;
    logic              ex_csr_access;
    rx_pkg::csr_addr_t ex_csr_addr;
    rx_pkg::word_t     ex_csr_wdata;
    rx_pkg::csr_op_t   ex_csr_op;

    // Pattern memory holds cols words per line
    rx_pkg::word_t pat [0:max_lines*cols-1];
    int            n_lines;
    int            setup_errs;
    int            chk_errs;
    logic          load_done;
    // Line the checker compares on the next falling edge
    logic          check_en;
    int            check_line;
    int            gap_len;
    int            gap_used;
    int unsigned   seed_ret;

    ex_stage #(
        .isa_c (1'b0)
    ) dut_i (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .stall_i         (stall),
        .flush_i         (flush),
        .valid_i         (valid),
        .alu_op_i        (alu_op),
        .op_a_i          (op_a),
        .op_b_i          (op_b),
        .rd_addr_i       (rd_addr),
        .mem_req_i       (mem_req),
        .mem_wen_i       (mem_wen),
        .reg_wen_i       (reg_wen),
        .pc_i            (pc),
        .branch_target_i (branch_target),
        .is_branch_i     (is_branch),
        .csr_access_i    (csr_access),
        .csr_op_i        (csr_op),
        .csr_rdata_i     (csr_rdata),
        .valid_o         (ex_valid),
        .rd_addr_o       (ex_rd_addr),
        .mem_req_o       (ex_mem_req),
        .mem_wen_o       (ex_mem_wen),
        .reg_wen_o       (ex_reg_wen),
        .alu_result_o    (ex_alu_result),
        .branch_taken_o  (ex_branch_taken),
        .branch_target_o (ex_branch_target),
        .trap_o          (ex_trap),
        .pc_o            (ex_pc),
        .csr_access_o    (ex_csr_access),
        .csr_addr_o      (ex_csr_addr),
        .csr_wdata_o     (ex_csr_wdata),
        .csr_op_o        (ex_csr_op)
    );

    ex_checker u_checker (
        .clk_i           (clk),
        .check_en_i      (check_en),
        .line_i          (check_line),
        .valid_i         (ex_valid),
        .alu_result_i    (ex_alu_result),
        .branch_taken_i  (ex_branch_taken),
        .trap_i          (ex_trap),
        .csr_addr_i      (ex_csr_addr),
        .mem_req_i       (ex_mem_req),
        .reg_wen_i       (ex_reg_wen),
        .mem_wen_i       (ex_mem_wen),
        .rd_addr_i       (ex_rd_addr),
        .pc_i            (ex_pc),
        .branch_target_i (ex_branch_target),
        .csr_access_i    (ex_csr_access),
        .csr_wdata_i     (ex_csr_wdata),
        .csr_op_i        (ex_csr_op),
        .err_cnt_o       (chk_errs)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////

    // Stage frozen so reset values stay visible until line 0
    task automatic drive_idle();
        stall         = 1'b1;
        flush         = 1'b0;
        valid         = 1'b0;
        alu_op        = rx_pkg::alu_add;
        op_a          = '0;
        op_b          = '0;
        rd_addr       = '0;
        mem_req       = 1'b0;
        mem_wen       = 1'b0;
        reg_wen       = 1'b0;
        pc            = '0;
        branch_target = '0;
        is_branch     = 1'b0;
        csr_access    = 1'b0;
        csr_op        = rx_pkg::csr_read;
        csr_rdata     = '0;
        check_en      = 1'b0;
        check_line    = 0;
    endtask

    // Unused words stay all ones and no stall column is all ones
    task automatic load_patterns();
        int fd;
        fd = $fopen("ex_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file ex_patterns.txt could not be opened");
            setup_errs++;
        end else begin
            $fclose(fd);
            for (int i = 0; i < max_lines * cols; i++) begin
                pat[i] = '1;
            end
            $readmemh("ex_patterns.txt", pat);
            while (n_lines < max_lines && pat[n_lines * cols] != '1) begin
                n_lines++;
            end
            if (n_lines == 0) begin
                $display("pattern file ex_patterns.txt holds no vectors");
                setup_errs++;
            end else if (pat[n_lines * cols - 1] == '1) begin
                $display("pattern file ex_patterns.txt ends in a short line");
                setup_errs++;
            end
        end
    endtask

    // Inputs change after the checker has sampled the previous line
    task automatic drive_line(input int k);
        int b;
        b = k * cols;
        stall         <= pat[b][0];
        flush         <= pat[b+1][0];
        valid         <= pat[b+2][0];
        alu_op        <= rx_pkg::alu_op_t'(pat[b+3][3:0]);
        op_a          <= pat[b+4];
        op_b          <= pat[b+5];
        is_branch     <= pat[b+6][0];
        branch_target <= pat[b+7];
        csr_access    <= pat[b+8][0];
        csr_rdata     <= pat[b+9];
        // Memory request and write enables follow valid
        mem_req       <= pat[b+2][0];
        mem_wen       <= pat[b+2][0];
        reg_wen       <= pat[b+2][0];
        // Rd index, PC and CSR op follow the line number
        rd_addr       <= rx_pkg::reg_addr_t'(k);
        pc            <= rx_pkg::word_t'(k * 4);
        csr_op        <= rx_pkg::csr_op_t'(k % 4);
        check_line    <= k;
        check_en      <= 1'b1;
    endtask

    //////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////

    initial begin
        n_lines    = 0;
        setup_errs = 0;
        gap_used   = 0;
        load_done  = 1'b0;
        seed_ret   = $urandom(rand_seed);
        rst_n      = 1'b0;
        drive_idle();
        load_patterns();
        load_done = 1'b1;
        if (setup_errs == 0) begin
            repeat (reset_cycles) @(negedge clk);
            rst_n <= 1'b1;
            for (int k = 0; k < n_lines; k++) begin
                // Gaps only go before unstalled lines that reload the stage
                if (pat[k * cols] == '0 && gap_used < gap_budget && ($urandom % 4) == 0) begin
                    gap_len = 1 + int'($urandom % 3);
                    repeat (gap_len) begin
                        @(negedge clk);
                        stall    <= 1'b1;
                        check_en <= 1'b0;
                    end
                    gap_used += gap_len;
                end
                @(negedge clk);
                drive_line(k);
            end
            // Last line is compared on this edge
            @(negedge clk);
            check_en <= 1'b0;
            @(posedge clk);
        end
        $display("Error count: total %0d, mismatches %0d, setup %0d",
                 setup_errs + chk_errs, chk_errs, setup_errs);
        if (setup_errs + chk_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the pattern count
    initial begin
        wait (load_done);
        #((n_lines + reset_cycles + 50) * clk_period);
        $display("timeout, the run did not end within %0d cycles",
                 n_lines + reset_cycles + 50);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== ex_patterns.txt ====
// st fl v op a b br target csr rdata | exp: valid result taken trap csr_addr
// Reset values under stall, then ALU ops, stall, branch, CSR and flush
1 0 0 0 00000000 00000000 0 00000000 0 00000000 0 00000000 0 0 000
0 0 1 0 800000F0 00000134 0 00000000 0 00000000 1 80000224 0 0 000
0 0 1 1 800000F0 00000134 0 00000000 0 00000000 1 7FFFFFBC 0 0 000
0 0 1 2 800000F0 00000134 0 00000000 0 00000000 1 00000030 0 0 000
0 0 1 3 800000F0 00000134 0 00000000 0 00000000 1 800001F4 0 0 000
0 0 1 4 800000F0 00000134 0 00000000 0 00000000 1 800001C4 0 0 000
0 0 1 5 800000F0 00000134 0 00000000 0 00000000 1 0F000000 0 0 000
0 0 1 6 800000F0 00000134 0 00000000 0 00000000 1 00000800 0 0 000
0 0 1 7 800000F0 00000134 0 00000000 0 00000000 1 FFFFF800 0 0 000
0 0 1 8 800000F0 00000134 0 00000000 0 00000000 1 00000001 0 0 000
0 0 1 9 800000F0 00000134 0 00000000 0 00000000 1 00000000 0 0 000
0 0 1 A 800000F0 00000134 0 00000000 0 00000000 1 00000000 0 0 000
0 0 1 B 800000F0 00000134 0 00000000 0 00000000 1 00000001 0 0 000
0 0 1 C 800000F0 00000134 0 00000000 0 00000000 1 00000001 0 0 000
0 0 1 D 800000F0 00000134 0 00000000 0 00000000 1 00000000 0 0 000
0 0 1 E 800000F0 00000134 0 00000000 0 00000000 1 00000000 0 0 000
0 0 1 F 800000F0 00000134 0 00000000 0 00000000 1 00000001 0 0 000
1 0 0 0 12345678 11111111 1 00000002 1 9ABCDEF0 1 00000001 0 0 000
1 0 1 1 00000000 FFFFFFFF 1 00000006 0 00000001 1 00000001 0 0 000
1 0 0 A 00000003 00000003 1 0000000A 1 00000003 1 00000001 0 0 000
0 0 1 A 00000005 00000005 1 00001000 0 00000000 1 00000001 1 0 000
0 0 1 B 00000005 00000005 1 00001002 0 00000000 1 00000000 0 0 000
0 0 1 C FFFFFFFF 00000001 1 00001002 0 00000000 1 00000001 1 1 000
0 0 0 C FFFFFFFF 00000001 1 00001002 0 00000000 0 00000001 1 0 000
0 0 1 F FFFFFFFF 00000001 1 00001004 0 00000000 1 00000001 1 0 000
0 0 1 0 000000AA 0ABCD345 0 00000000 1 11112220 1 11112220 0 0 345
1 0 0 0 00000000 00000000 0 00000000 0 11112220 1 11112220 0 0 345
1 0 0 0 00000000 00000000 0 00000000 0 55556666 1 11112220 0 0 345
1 0 1 1 00000001 00000FFF 0 00000000 1 77770000 1 11112220 0 0 345
0 0 1 1 00000010 00000003 0 00000000 0 77770000 1 0000000D 0 0 345
0 0 1 A 00000007 00000007 1 00002002 0 00000000 1 00000001 1 1 345
1 1 0 0 00000000 00000000 0 00000000 0 00000000 1 00000001 1 1 345
0 1 1 0 00000009 00000009 1 00002002 1 00000000 0 00000001 0 0 345

// ==== all.f ====
rx_pkg.sv
ex_bus_if.sv
ex_decode_reg.sv
ex_alu.sv
ex_result.sv
ex_stage.sv
ex_checker.sv
tb_ex_stage.sv

// ==== Makefile ====
SRCS = rx_pkg.sv ex_bus_if.sv ex_decode_reg.sv ex_alu.sv ex_result.sv ex_stage.sv \
       ex_checker.sv tb_ex_stage.sv

obj_dir/Vtb_ex_stage: all.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f --top-module tb_ex_stage

run: obj_dir/Vtb_ex_stage
	./obj_dir/Vtb_ex_stage > sim.log 2>&1
	cat sim.log
	! grep -q "Simulation FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
